//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_lsu
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter %.sv,$(shell cat $(FILELIST))) lsu_cfg.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM) lsu_patterns.txt
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+.
lsu_pkg.sv
lsu_decode.sv
lsu_req_queue.sv
lsu_bus_master.sv
lsu_load_align.sv
lsu_top.sv
tb_lsu.sv

//--- lsu_bus_master.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_bus_master
    import lsu_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   deq_valid,
    output logic                   deq_ready,
    input  lsu_op_e                head_op,
    input  mem_size_e              head_size,
    input  logic                   head_is_unsigned,
    input  logic                   head_misaligned,
    input  logic [`LSU_XLEN-1:0]   head_addr,
    input  logic [`LSU_XLEN-1:0]   head_wdata,
    input  logic [`LSU_STRB_W-1:0] head_wstrb,
    input  logic [`LSU_XLEN-1:0]   head_result,
    input  logic [`LSU_XLEN-1:0]   head_inst,
    output logic                   awvalid,
    input  logic                   awready,
    output logic [`LSU_XLEN-1:0]   awaddr,
    output logic                   wvalid,
    input  logic                   wready,
    output logic [`LSU_XLEN-1:0]   wdata,
    output logic [`LSU_STRB_W-1:0] wstrb,
    input  logic                   bvalid,
    output logic                   bready,
    input  logic [1:0]             bresp,
    output logic                   arvalid,
    input  logic                   arready,
    output logic [`LSU_XLEN-1:0]   araddr,
    input  logic                   rvalid,
    output logic                   rready,
    input  logic [`LSU_XLEN-1:0]   rdata,
    input  logic [1:0]             rresp,
    output logic [`LSU_XLEN-1:0]   rd_data,
    output mem_size_e              rd_size,
    output logic                   rd_unsigned,
    output logic [1:0]             rd_offset,
    input  logic [`LSU_XLEN-1:0]   aligned_data,
    output logic                   wb_valid,
    input  logic                   wb_ready,
    output logic [`LSU_XLEN-1:0]   wb_inst,
    output logic [`LSU_XLEN-1:0]   wb_data,
    output logic                   wb_error
);

    bus_state_e state;

    // request being worked on
    mem_size_e              cur_size;
    logic                   cur_unsigned;
    logic [`LSU_XLEN-1:0]   cur_addr;
    logic [`LSU_XLEN-1:0]   cur_wdata;
    logic [`LSU_STRB_W-1:0] cur_wstrb;
    logic [`LSU_XLEN-1:0]   cur_inst;
    logic [`LSU_XLEN-1:0]   res_q;  // writeback value
    logic                   err_q;

    assign deq_ready = (state == ST_IDLE) && deq_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (deq_valid) begin
                    if (head_op == OP_PASS || head_misaligned) begin
                        state <= ST_WB;
                    end else if (head_op == OP_STORE) begin
                        state <= ST_WR_ADDR;
                    end else begin
                        state <= ST_RD_ADDR;
                    end
                end
                ST_WR_ADDR: if (awready) state <= ST_WR_DATA;
                ST_WR_DATA: if (wready) state <= ST_WR_RESP;
                ST_WR_RESP: if (bvalid) state <= ST_WB;
                ST_RD_ADDR: if (arready) state <= ST_RD_DATA;
                ST_RD_DATA: if (rvalid) state <= ST_WB;
                ST_WB:      if (wb_ready) state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (deq_ready) begin
            cur_size     <= head_size;
            cur_unsigned <= head_is_unsigned;
            cur_addr     <= head_addr;
            cur_wdata    <= head_wdata;
            cur_wstrb    <= head_wstrb;
            cur_inst     <= head_inst;
            res_q        <= head_result; // stores and pass ops keep this
            err_q        <= head_misaligned;
        end
        if (state == ST_WR_RESP && bvalid) begin
            err_q <= (bresp != `LSU_RESP_OKAY);
        end
        if (state == ST_RD_DATA && rvalid) begin
            res_q <= aligned_data;
            err_q <= (rresp != `LSU_RESP_OKAY);
        end
    end

    assign awvalid = (state == ST_WR_ADDR);
    assign wvalid  = (state == ST_WR_DATA);
    assign bready  = (state == ST_WR_RESP);
    assign arvalid = (state == ST_RD_ADDR);
    assign rready  = (state == ST_RD_DATA);
    assign wb_valid = (state == ST_WB);

    assign awaddr = cur_addr;
    assign araddr = cur_addr;
    assign wdata  = cur_wdata;
    assign wstrb  = cur_wstrb;

    // raw beat plus what the aligner needs
    assign rd_data     = rdata;
    assign rd_size     = cur_size;
    assign rd_unsigned = cur_unsigned;
    assign rd_offset   = cur_addr[1:0];

    assign wb_inst  = cur_inst;
    assign wb_data  = res_q;
    assign wb_error = err_q;

    a_aw_hold: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr));

    a_w_hold: assert property (@(posedge clock) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb));

    a_ar_hold: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr));

    a_wb_hold: assert property (@(posedge clock) disable iff (reset)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_data)
            && $stable(wb_error) && $stable(wb_inst));

endmodule

//--- lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data and address width of the unit
`define LSU_XLEN 32

// one strobe bit per byte lane
`define LSU_STRB_W 4

// requests that can wait between decode and the bus
`define LSU_QUEUE_DEPTH 2

// AXI response codes, 2 bits like bresp/rresp
`define LSU_RESP_OKAY 2'b00
`define LSU_RESP_SLVERR 2'b10

`endif

//--- lsu_decode.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_decode
    import lsu_pkg::*;
(
    input  logic [`LSU_XLEN-1:0]   inst,
    input  logic [`LSU_XLEN-1:0]   addr,
    input  logic [`LSU_XLEN-1:0]   wdata,
    output lsu_op_e                op,
    output mem_size_e              size,
    output logic                   is_unsigned,
    output logic                   misaligned,
    output logic [`LSU_XLEN-1:0]   lane_wdata,
    output logic [`LSU_STRB_W-1:0] wstrb
);

    logic [2:0] funct3;
    logic [4:0] lane_shift; // bit offset of the addressed byte
    logic       is_mem;

    assign funct3     = inst[14:12];
    assign lane_shift = {addr[1:0], 3'b000};
    assign is_mem     = (op != OP_PASS);

    // operation, size and signedness
    always_comb begin
        op          = OP_PASS;
        size        = SIZE_WORD;
        is_unsigned = 1'b0;
        case (inst[6:0])
            OPC_LOAD: begin
                op          = OP_LOAD;
                is_unsigned = funct3[2]; // lbu / lhu
            end
            OPC_STORE: op = OP_STORE;
            default: op = OP_PASS;
        endcase
        case (funct3[1:0])
            2'b00:   size = SIZE_BYTE;
            2'b01:   size = SIZE_HALF;
            default: size = SIZE_WORD;
        endcase
    end

    // caught here so it never reaches the bus
    always_comb begin
        misaligned = 1'b0;
        if (is_mem) begin
            case (size)
                SIZE_HALF: misaligned = addr[0];
                SIZE_WORD: misaligned = (addr[1:0] != 2'b00);
                default:   misaligned = 1'b0;
            endcase
        end
    end

    // store data into its byte lanes
    always_comb begin
        lane_wdata = wdata;
        wstrb      = '0;
        case (size)
            SIZE_BYTE: begin
                lane_wdata = {{(`LSU_XLEN-8){1'b0}}, wdata[7:0]} << lane_shift;
                wstrb      = `LSU_STRB_W'(1) << addr[1:0];
            end
            SIZE_HALF: begin
                lane_wdata = {{(`LSU_XLEN-16){1'b0}}, wdata[15:0]} << lane_shift;
                wstrb      = addr[1] ? `LSU_STRB_W'('b1100) : `LSU_STRB_W'('b0011);
            end
            default: begin
                lane_wdata = wdata;
                wstrb      = '1;
            end
        endcase
        if (op != OP_STORE || misaligned) begin
            wstrb = '0; // nothing gets written
        end
    end

endmodule

//--- lsu_load_align.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_load_align
    import lsu_pkg::*;
(
    input  logic [`LSU_XLEN-1:0] rd_data,
    input  mem_size_e            rd_size,
    input  logic                 rd_unsigned,
    input  logic [1:0]           rd_offset,
    output logic [`LSU_XLEN-1:0] aligned_data
);

    logic [`LSU_XLEN-1:0] shifted; // addressed byte moved to bit 0
    logic [7:0]           byte_val;
    logic [15:0]          half_val;

    assign shifted  = rd_data >> {rd_offset, 3'b000};
    assign byte_val = shifted[7:0];
    assign half_val = shifted[15:0];

    always_comb begin
        case (rd_size)
            SIZE_BYTE: begin
                if (rd_unsigned) begin
                    aligned_data = {{(`LSU_XLEN-8){1'b0}}, byte_val};
                end else begin
                    aligned_data = {{(`LSU_XLEN-8){byte_val[7]}}, byte_val};
                end
            end
            SIZE_HALF: begin
                if (rd_unsigned) begin
                    aligned_data = {{(`LSU_XLEN-16){1'b0}}, half_val};
                end else begin
                    aligned_data = {{(`LSU_XLEN-16){half_val[15]}}, half_val};
                end
            end
            default: aligned_data = rd_data; // lw
        endcase
    end

endmodule

//--- lsu_patterns.txt
// one test per line, six 32-bit hex fields joined by underscores
// inst _ addr _ store data _ execute result _ expected wb_data _ expected wb_error
003100B3_00000000_00000000_12345678_12345678_00000000
00310093_00000003_00000000_00000042_00000042_00000000
00000083_00000000_00000000_00000000_0000003C_00000000
00000083_00000001_00000000_00000000_0000005A_00000000
00000083_00000002_00000000_00000000_FFFFFFC3_00000000
00000083_00000003_00000000_00000000_FFFFFFA5_00000000
00004083_00000000_00000000_00000000_0000003C_00000000
00004083_00000002_00000000_00000000_000000C3_00000000
00004083_00000007_00000000_00000000_000000A4_00000000
00001083_00000000_00000000_00000000_00005A3C_00000000
00001083_00000006_00000000_00000000_FFFFA4C2_00000000
00005083_00000002_00000000_00000000_0000A5C3_00000000
00005083_00000004_00000000_00000000_00005B3D_00000000
00002083_00000008_00000000_00000000_A7C1583E_00000000
// stores, each read back as a whole word
00000023_00000041_12345678_00000041_00000041_00000000
00002083_00000040_00000000_00000000_B5D3782C_00000000
00001023_00000022_0000BEEF_00000022_00000022_00000000
00002083_00000020_00000000_00000000_BEEF5234_00000000
00002023_00000024_CAFEF00D_00000024_00000024_00000000
00002083_00000024_00000000_00000000_CAFEF00D_00000000
00000023_0000000F_000000EE_0000000F_0000000F_00000000
00002083_0000000C_00000000_00000000_EEC0593F_00000000
00001023_00000010_11112222_00000010_00000010_00000000
00002083_00000010_00000000_00000000_A1C72222_00000000
00000023_00000014_00000055_00000014_00000014_00000000
00000023_00000016_00000066_00000016_00000016_00000000
00002083_00000014_00000000_00000000_A0665F55_00000000
// misaligned accesses, then word 6 must be untouched
00001083_00000001_00000000_00001111_00001111_00000001
00002083_00000002_00000000_00002222_00002222_00000001
00001023_00000019_0000FFFF_00003333_00003333_00000001
00002023_0000001A_00000000_00004444_00004444_00000001
00002083_00000018_00000000_00000000_A3C55C3A_00000000
// slave error region
00002083_F0000000_00000000_00000000_00000000_00000001
00002023_F0000010_AAAAAAAA_00005555_00005555_00000001
00004083_F0000003_00000000_00000000_00000000_00000001
00002083_00000010_00000000_00000000_A1C72222_00000000
003100B3_00000000_00000000_FFFFFFFF_FFFFFFFF_00000000

//--- lsu_pkg.sv
package lsu_pkg;

    // RV32I major opcodes the unit cares about
    typedef enum logic [6:0] {
        OPC_LOAD  = 7'b0000011,
        OPC_STORE = 7'b0100011
    } lsu_opcode_e;

    typedef enum logic [1:0] {
        OP_PASS  = 2'd0, // not a memory op, result goes straight through
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } lsu_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_WR_ADDR = 3'd1,
        ST_WR_DATA = 3'd2,
        ST_WR_RESP = 3'd3,
        ST_RD_ADDR = 3'd4,
        ST_RD_DATA = 3'd5,
        ST_WB      = 3'd6
    } bus_state_e;

endpackage

//--- lsu_req_queue.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_req_queue
    import lsu_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   enq_valid,
    output logic                   enq_ready,
    input  lsu_op_e                op,
    input  mem_size_e              size,
    input  logic                   is_unsigned,
    input  logic                   misaligned,
    input  logic [`LSU_XLEN-1:0]   addr,
    input  logic [`LSU_XLEN-1:0]   wdata,
    input  logic [`LSU_STRB_W-1:0] wstrb,
    input  logic [`LSU_XLEN-1:0]   result,
    input  logic [`LSU_XLEN-1:0]   inst,
    output logic                   deq_valid,
    input  logic                   deq_ready,
    output lsu_op_e                head_op,
    output mem_size_e              head_size,
    output logic                   head_is_unsigned,
    output logic                   head_misaligned,
    output logic [`LSU_XLEN-1:0]   head_addr,
    output logic [`LSU_XLEN-1:0]   head_wdata,
    output logic [`LSU_STRB_W-1:0] head_wstrb,
    output logic [`LSU_XLEN-1:0]   head_result,
    output logic [`LSU_XLEN-1:0]   head_inst
);

    localparam int DEPTH = `LSU_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    lsu_op_e                op_mem       [DEPTH];
    mem_size_e              size_mem     [DEPTH];
    logic                   unsigned_mem [DEPTH];
    logic                   misalign_mem [DEPTH];
    logic [`LSU_XLEN-1:0]   addr_mem     [DEPTH];
    logic [`LSU_XLEN-1:0]   wdata_mem    [DEPTH];
    logic [`LSU_STRB_W-1:0] wstrb_mem    [DEPTH];
    logic [`LSU_XLEN-1:0]   result_mem   [DEPTH];
    logic [`LSU_XLEN-1:0]   inst_mem     [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign enq_ready = (count != CNT_W'(DEPTH));
    assign deq_valid = (count != '0);
    assign push      = enq_valid && enq_ready;
    assign pop       = deq_valid && deq_ready;

    always_ff @(posedge clock) begin
        if (push) begin
            op_mem[wr_ptr]       <= op;
            size_mem[wr_ptr]     <= size;
            unsigned_mem[wr_ptr] <= is_unsigned;
            misalign_mem[wr_ptr] <= misaligned;
            addr_mem[wr_ptr]     <= addr;
            wdata_mem[wr_ptr]    <= wdata;
            wstrb_mem[wr_ptr]    <= wstrb;
            result_mem[wr_ptr]   <= result;
            inst_mem[wr_ptr]     <= inst;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle or push+pop
            endcase
        end
    end

    assign head_op          = op_mem[rd_ptr];
    assign head_size        = size_mem[rd_ptr];
    assign head_is_unsigned = unsigned_mem[rd_ptr];
    assign head_misaligned  = misalign_mem[rd_ptr];
    assign head_addr        = addr_mem[rd_ptr];
    assign head_wdata       = wdata_mem[rd_ptr];
    assign head_wstrb       = wstrb_mem[rd_ptr];
    assign head_result      = result_mem[rd_ptr];
    assign head_inst        = inst_mem[rd_ptr];

    // a full queue takes no new entry over its head
    a_no_enq_full: assert property (@(posedge clock) disable iff (reset)
        count == CNT_W'(DEPTH) && !pop |=> $stable(head_inst) && $stable(head_addr));

    // bus master only takes an entry that is there
    a_no_deq_empty: assert property (@(posedge clock) disable iff (reset)
        deq_ready |-> deq_valid);

endmodule

//--- lsu_top.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [`LSU_XLEN-1:0]   in_inst,
    input  logic [`LSU_XLEN-1:0]   in_addr,
    input  logic [`LSU_XLEN-1:0]   in_wdata,
    input  logic [`LSU_XLEN-1:0]   in_result,
    output logic                   awvalid,
    input  logic                   awready,
    output logic [`LSU_XLEN-1:0]   awaddr,
    output logic                   wvalid,
    input  logic                   wready,
    output logic [`LSU_XLEN-1:0]   wdata,
    output logic [`LSU_STRB_W-1:0] wstrb,
    input  logic                   bvalid,
    output logic                   bready,
    input  logic [1:0]             bresp,
    output logic                   arvalid,
    input  logic                   arready,
    output logic [`LSU_XLEN-1:0]   araddr,
    input  logic                   rvalid,
    output logic                   rready,
    input  logic [`LSU_XLEN-1:0]   rdata,
    input  logic [1:0]             rresp,
    output logic                   wb_valid,
    input  logic                   wb_ready,
    output logic [`LSU_XLEN-1:0]   wb_inst,
    output logic [`LSU_XLEN-1:0]   wb_data,
    output logic                   wb_error
);

    // decoder outputs
    lsu_op_e                dec_op;
    mem_size_e              dec_size;
    logic                   dec_unsigned;
    logic                   dec_misaligned;
    logic [`LSU_XLEN-1:0]   dec_wdata;
    logic [`LSU_STRB_W-1:0] dec_wstrb;

    // queue head
    logic                   deq_valid;
    logic                   deq_ready;
    lsu_op_e                head_op;
    mem_size_e              head_size;
    logic                   head_is_unsigned;
    logic                   head_misaligned;
    logic [`LSU_XLEN-1:0]   head_addr;
    logic [`LSU_XLEN-1:0]   head_wdata;
    logic [`LSU_STRB_W-1:0] head_wstrb;
    logic [`LSU_XLEN-1:0]   head_result;
    logic [`LSU_XLEN-1:0]   head_inst;

    // bus master to aligner
    logic [`LSU_XLEN-1:0]   rd_data;
    mem_size_e              rd_size;
    logic                   rd_unsigned;
    logic [1:0]             rd_offset;
    logic [`LSU_XLEN-1:0]   aligned_data;

    lsu_decode i_decode (
        .inst(in_inst), .addr(in_addr), .wdata(in_wdata),
        .op(dec_op), .size(dec_size), .is_unsigned(dec_unsigned),
        .misaligned(dec_misaligned), .lane_wdata(dec_wdata), .wstrb(dec_wstrb)
    );

    lsu_req_queue i_queue (
        .clock(clock), .reset(reset),
        .enq_valid(in_valid), .enq_ready(in_ready),
        .op(dec_op), .size(dec_size), .is_unsigned(dec_unsigned),
        .misaligned(dec_misaligned), .addr(in_addr), .wdata(dec_wdata),
        .wstrb(dec_wstrb), .result(in_result), .inst(in_inst),
        .deq_valid(deq_valid), .deq_ready(deq_ready),
        .head_op(head_op), .head_size(head_size), .head_is_unsigned(head_is_unsigned),
        .head_misaligned(head_misaligned), .head_addr(head_addr),
        .head_wdata(head_wdata), .head_wstrb(head_wstrb),
        .head_result(head_result), .head_inst(head_inst)
    );

    lsu_bus_master i_bus (
        .clock(clock), .reset(reset),
        .deq_valid(deq_valid), .deq_ready(deq_ready),
        .head_op(head_op), .head_size(head_size), .head_is_unsigned(head_is_unsigned),
        .head_misaligned(head_misaligned), .head_addr(head_addr),
        .head_wdata(head_wdata), .head_wstrb(head_wstrb),
        .head_result(head_result), .head_inst(head_inst),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .rd_data(rd_data), .rd_size(rd_size), .rd_unsigned(rd_unsigned),
        .rd_offset(rd_offset), .aligned_data(aligned_data),
        .wb_valid(wb_valid), .wb_ready(wb_ready), .wb_inst(wb_inst),
        .wb_data(wb_data), .wb_error(wb_error)
    );

    lsu_load_align i_align (
        .rd_data(rd_data), .rd_size(rd_size), .rd_unsigned(rd_unsigned),
        .rd_offset(rd_offset), .aligned_data(aligned_data)
    );

endmodule

//--- tb_lsu.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module tb_lsu;

    localparam int PAT_MAX   = 64;
    localparam int MEM_WORDS = 64;

    logic                   clock = 1'b0;
    logic                   reset;
    logic                   in_valid;
    logic                   in_ready;
    logic [`LSU_XLEN-1:0]   in_inst;
    logic [`LSU_XLEN-1:0]   in_addr;
    logic [`LSU_XLEN-1:0]   in_wdata;
    logic [`LSU_XLEN-1:0]   in_result;

    // AXI4-Lite, slave side driven by the memory model
    logic                   awvalid;
    logic                   awready = 1'b0;
    logic [`LSU_XLEN-1:0]   awaddr;
    logic                   wvalid;
    logic                   wready = 1'b0;
    logic [`LSU_XLEN-1:0]   wdata;
    logic [`LSU_STRB_W-1:0] wstrb;
    logic                   bvalid = 1'b0;
    logic                   bready;
    logic [1:0]             bresp = `LSU_RESP_OKAY;
    logic                   arvalid;
    logic                   arready = 1'b0;
    logic [`LSU_XLEN-1:0]   araddr;
    logic                   rvalid = 1'b0;
    logic                   rready;
    logic [`LSU_XLEN-1:0]   rdata = '0;
    logic [1:0]             rresp = `LSU_RESP_OKAY;

    logic                   wb_valid;
    logic                   wb_ready = 1'b0;
    logic [`LSU_XLEN-1:0]   wb_inst;
    logic [`LSU_XLEN-1:0]   wb_data;
    logic                   wb_error;

    logic [6*`LSU_XLEN-1:0] patterns [0:PAT_MAX-1]; // one row per test
    logic [`LSU_XLEN-1:0]   mem [0:MEM_WORDS-1];

    int num_pat     = 0;
    int wb_count    = 0;
    int errors      = 0;
    int cycles      = 0;
    int cycle_limit = 0;

    // memory model state
    logic [31:0]            rng = 32'd30058;
    logic                   w_hs = 1'b0;
    logic                   b_hs = 1'b0;
    logic                   ar_hs = 1'b0;
    logic                   r_hs = 1'b0;
    logic                   b_pend = 1'b0;
    logic                   r_pend = 1'b0;
    logic [`LSU_XLEN-1:0]   wr_addr_q = '0;
    logic [1:0]             wr_resp_q = `LSU_RESP_OKAY;
    logic [`LSU_XLEN-1:0]   rd_word_q = '0;
    logic [1:0]             rd_resp_q = `LSU_RESP_OKAY;

    lsu_top i_lsu_top (.*);

    always #10 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // column 0 sits in the top bits of the row
    function automatic logic [31:0] pat_field(input logic [191:0] row, input int col);
        return row[(5 - col) * 32 +: 32];
    endfunction

    function automatic logic in_error_region(input logic [31:0] addr);
        return addr[31:24] == 8'hF0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i[5:0]] = i * 32'h0101_0101 ^ 32'hA5C3_5A3C;
        end
    end

    // sees each handshake before the edge that completes it
    always @(negedge clock) begin : bus_watch
        logic [31:0] mask;
        w_hs  = wvalid && wready;
        b_hs  = bvalid && bready;
        ar_hs = arvalid && arready;
        r_hs  = rvalid && rready;
        if (awvalid && awready) begin
            wr_addr_q = awaddr;
        end
        if (w_hs) begin
            if (in_error_region(wr_addr_q)) begin
                wr_resp_q = `LSU_RESP_SLVERR; // region is read-only, nothing stored
            end else begin
                mask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
                mem[wr_addr_q[7:2]] = (mem[wr_addr_q[7:2]] & ~mask) | (wdata & mask);
                wr_resp_q = `LSU_RESP_OKAY;
            end
        end
        if (ar_hs) begin
            if (in_error_region(araddr)) begin
                rd_word_q = '0;
                rd_resp_q = `LSU_RESP_SLVERR;
            end else begin
                rd_word_q = mem[araddr[7:2]];
                rd_resp_q = `LSU_RESP_OKAY;
            end
        end
    end

    // random readies and response delays
    always @(posedge clock) begin : bus_respond
        #1;
        if (reset) begin
            awready  = 1'b0;
            wready   = 1'b0;
            arready  = 1'b0;
            wb_ready = 1'b0;
            bvalid   = 1'b0;
            rvalid   = 1'b0;
            b_pend   = 1'b0;
            r_pend   = 1'b0;
        end else begin
            rng      = xorshift32(rng);
            awready  = rng[3];
            wready   = rng[7];
            arready  = rng[11];
            wb_ready = rng[15] | rng[19]; // stalls a quarter of the time
            if (w_hs) b_pend = 1'b1;
            if (ar_hs) r_pend = 1'b1;
            if (b_hs) bvalid = 1'b0;
            if (r_hs) rvalid = 1'b0;
            if (b_pend && rng[23]) begin
                bvalid = 1'b1;
                bresp  = wr_resp_q;
                b_pend = 1'b0;
            end
            if (r_pend && rng[27]) begin
                rvalid = 1'b1;
                rdata  = rd_word_q;
                rresp  = rd_resp_q;
                r_pend = 1'b0;
            end
        end
    end

    // writebacks must come back in input order
    always @(negedge clock) begin : collect_wb
        logic [191:0] row;
        int           errors_before;
        string        verdict;
        if (!reset && wb_valid && wb_ready) begin
            if (wb_count >= num_pat) begin
                $display("unexpected writeback after the last pattern, inst %h", wb_inst);
                errors++;
            end else begin
                row           = patterns[wb_count[5:0]];
                errors_before = errors;
                check_value("wb_inst", wb_inst, pat_field(row, 0));
                check_value("wb_data", wb_data, pat_field(row, 4));
                check_value("wb_error", {31'b0, wb_error}, pat_field(row, 5));
                if (errors == errors_before) begin
                    verdict = "ok";
                end else begin
                    verdict = "mismatch";
                end
                $display("pattern %0d inst %h addr %h data %h error %0d %s", wb_count,
                         wb_inst, pat_field(row, 1), wb_data, wb_error, verdict);
            end
            wb_count++;
        end
    end

    always @(posedge clock) begin : watchdog
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d writebacks seen",
                     cycles, wb_count, num_pat);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin : run_patterns
        int reset_errors;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_inst   = '0;
        in_addr   = '0;
        in_wdata  = '0;
        in_result = '0;
        for (int i = 0; i < PAT_MAX; i++) begin
            patterns[i[5:0]] = '0;
        end
        $readmemh("lsu_patterns.txt", patterns);
        while (num_pat < PAT_MAX && pat_field(patterns[num_pat[5:0]], 0) != '0) begin
            num_pat++; // a zero instruction marks the end
        end
        if (num_pat == 0) begin
            $display("no patterns were read from lsu_patterns.txt");
        end
        cycle_limit = 40 * num_pat + 100;

        repeat (5) @(posedge clock);
        #1;
        // idle outputs once reset has been seen
        reset_errors = errors;
        check_value("in_ready", {31'b0, in_ready}, 32'd1);
        check_value("wb_valid", {31'b0, wb_valid}, 32'd0);
        check_value("awvalid", {31'b0, awvalid}, 32'd0);
        check_value("wvalid", {31'b0, wvalid}, 32'd0);
        check_value("bready", {31'b0, bready}, 32'd0);
        check_value("arvalid", {31'b0, arvalid}, 32'd0);
        check_value("rready", {31'b0, rready}, 32'd0);
        if (errors == reset_errors) begin
            $display("reset state ok");
        end else begin
            $display("reset state mismatch");
        end
        reset = 1'b0;

        for (int p = 0; p < num_pat; p++) begin
            in_valid  = 1'b1;
            in_inst   = pat_field(patterns[p[5:0]], 0);
            in_addr   = pat_field(patterns[p[5:0]], 1);
            in_wdata  = pat_field(patterns[p[5:0]], 2);
            in_result = pat_field(patterns[p[5:0]], 3);
            @(negedge clock);
            while (!in_ready) @(negedge clock);
            @(posedge clock);
            #1;
        end
        in_valid = 1'b0;

        wait (wb_count >= num_pat);
        repeat (10) @(posedge clock); // room for a stray extra writeback
        $display("%0d patterns, %0d writebacks, %0d errors", num_pat, wb_count, errors);
        if (errors == 0 && num_pat > 0 && wb_count == num_pat) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
